//--- dcache.sv
`timescale 1ns/10ps
`include "tartaruga_consts.svh"

module dcache (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  riscv_pkg::bus32_t addr_i,
    input  riscv_pkg::bus32_t data_wr_i,
    input  logic              we_i,
    input  logic              valid_i,
    output riscv_pkg::bus32_t data_rd_o,
    output logic              ready_o,
    mem_bus_if.requester      mem
);

    import riscv_pkg::*;
    import tartaruga_pkg::*;

    localparam int NUM_SETS    = `DC_NUM_SETS;
    localparam int WAYS        = `DC_WAYS;
    localparam int WORD_BITS   = $clog2(`WORDS_PER_LINE);
    localparam int INDEX_BITS  = $clog2(NUM_SETS);
    localparam int OFFSET_BITS = WORD_BITS + 2;
    localparam int TAG_BITS    = 32 - INDEX_BITS - OFFSET_BITS;

    logic                  valid_q [NUM_SETS][WAYS];
    logic                  dirty_q [NUM_SETS][WAYS];
    age_t                  age_q   [NUM_SETS][WAYS];
    logic [TAG_BITS-1:0]   tag_q   [NUM_SETS][WAYS];
    line_t                 data_q  [NUM_SETS][WAYS];

    logic [INDEX_BITS-1:0] index;
    logic [TAG_BITS-1:0]   tag_in;
    logic [WORD_BITS-1:0]  word_off;

    assign index    = addr_i[OFFSET_BITS +: INDEX_BITS];
    assign tag_in   = addr_i[31 -: TAG_BITS];
    assign word_off = addr_i[2 +: WORD_BITS];

    logic hit;
    way_t hit_way;
    way_t victim_way;

    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (valid_q[index][w] && (tag_q[index][w] == tag_in)) begin
                hit     = 1'b1;
                hit_way = way_t'(w);
            end
        end
    end

    always_comb begin    // oldest way of the addressed set
        victim_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (age_q[index][w] == '1) begin
                victim_way = way_t'(w);
            end
        end
    end

    dc_state_t             state_q;
    dc_state_t             state_d;
    logic [INDEX_BITS-1:0] pend_idx_q;
    logic [TAG_BITS-1:0]   pend_tag_q;
    logic [WORD_BITS-1:0]  pend_off_q;
    bus32_t                pend_data_q;
    logic                  pend_we_q;
    way_t                  victim_q;

    logic miss_start;
    logic hit_wr;
    logic refill;
    logic wb_done;

    assign miss_start = (state_q == IDLE) && valid_i && !hit;
    assign hit_wr     = (state_q == IDLE) && valid_i && hit && we_i;
    assign refill     = mem.rsp_valid && ((state_q == READ_MISS) || (state_q == WRITE_MISS));
    assign wb_done    = mem.rsp_valid && (state_q == WRITE_BACK);

    assign ready_o   = (state_q == IDLE) && valid_i && hit;
    assign data_rd_o = hit ? data_q[index][hit_way][word_off*32 +: 32] : '0;

    // age update on a hit or on a refill, never both in one cycle
    logic                  touch_en;
    logic [INDEX_BITS-1:0] touch_idx;
    way_t                  touch_way;

    assign touch_en  = refill || ((state_q == IDLE) && valid_i && hit);
    assign touch_idx = refill ? pend_idx_q : index;
    assign touch_way = refill ? victim_q : hit_way;

    line_t fill_line;

    always_comb begin
        fill_line = mem.rdata;
        if (pend_we_q) begin
            fill_line[pend_off_q*32 +: 32] = pend_data_q;    // write miss merge
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (miss_start) begin
                    if (valid_q[index][victim_way] && dirty_q[index][victim_way]) begin
                        state_d = WRITE_BACK;
                    end else if (we_i) begin
                        state_d = WRITE_MISS;
                    end else begin
                        state_d = READ_MISS;
                    end
                end
            end
            WRITE_BACK: begin
                if (mem.rsp_valid) begin
                    state_d = pend_we_q ? WRITE_MISS : READ_MISS;
                end
            end
            READ_MISS, WRITE_MISS: begin
                if (mem.rsp_valid) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= IDLE;
            for (int s = 0; s < NUM_SETS; s++) begin
                for (int w = 0; w < WAYS; w++) begin
                    valid_q[s][w] <= 1'b0;
                    dirty_q[s][w] <= 1'b0;
                    age_q[s][w]   <= age_t'(w);
                end
            end
        end else begin
            state_q <= state_d;
            if (refill) begin
                valid_q[pend_idx_q][victim_q] <= 1'b1;
                dirty_q[pend_idx_q][victim_q] <= pend_we_q;
            end
            if (wb_done) begin
                dirty_q[pend_idx_q][victim_q] <= 1'b0;
            end
            if (hit_wr) begin
                dirty_q[index][hit_way] <= 1'b1;
            end
            if (touch_en) begin
                for (int w = 0; w < WAYS; w++) begin
                    if (way_t'(w) == touch_way) begin
                        age_q[touch_idx][w] <= '0;
                    end else if (age_q[touch_idx][w] != '1) begin
                        age_q[touch_idx][w] <= age_q[touch_idx][w] + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (miss_start) begin
            pend_idx_q  <= index;
            pend_tag_q  <= tag_in;
            pend_off_q  <= word_off;
            pend_data_q <= data_wr_i;
            pend_we_q   <= we_i;
            victim_q    <= victim_way;
        end
        if (refill) begin
            tag_q[pend_idx_q][victim_q]  <= pend_tag_q;
            data_q[pend_idx_q][victim_q] <= fill_line;
        end
        if (hit_wr) begin
            data_q[index][hit_way][word_off*32 +: 32] <= data_wr_i;
        end
    end

    assign mem.req_valid = (state_q != IDLE);
    assign mem.we        = (state_q == WRITE_BACK);
    assign mem.addr      = (state_q == WRITE_BACK)
                         ? {tag_q[pend_idx_q][victim_q], pend_idx_q, {OFFSET_BITS{1'b0}}}
                         : {pend_tag_q, pend_idx_q, {OFFSET_BITS{1'b0}}};
    assign mem.wdata     = data_q[pend_idx_q][victim_q];    // whole victim line

    a_ready_idle: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (state_q != IDLE) |-> !ready_o);

    // the core still holds its access, so it hits right after the refill
    a_refill_hit: assert property (@(posedge clk_i) disable iff (!rstn_i)
        refill |=> (ready_o || !valid_i));

    a_addr_aligned: assert property (@(posedge clk_i) disable iff (!rstn_i)
        mem.req_valid |-> (mem.addr[OFFSET_BITS-1:0] == '0));

endmodule

//--- icache.sv
`timescale 1ns/10ps
`include "tartaruga_consts.svh"

module icache (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  riscv_pkg::bus32_t addr_i,
    input  logic              valid_i,
    output riscv_pkg::instr_t instr_o,
    output logic              ready_o,
    mem_bus_if.requester      mem
);

    import tartaruga_pkg::*;

    localparam int NUM_LINES   = `IC_NUM_LINES;
    localparam int WORD_BITS   = $clog2(`WORDS_PER_LINE);
    localparam int INDEX_BITS  = $clog2(NUM_LINES);
    localparam int OFFSET_BITS = WORD_BITS + 2;
    localparam int TAG_BITS    = 32 - INDEX_BITS - OFFSET_BITS;

    logic                  valid_q [NUM_LINES];
    logic [TAG_BITS-1:0]   tag_q   [NUM_LINES];
    line_t                 line_q  [NUM_LINES];

    logic [INDEX_BITS-1:0] index;
    logic [TAG_BITS-1:0]   tag_in;
    logic [WORD_BITS-1:0]  word_off;
    logic                  hit;

    assign index    = addr_i[OFFSET_BITS +: INDEX_BITS];
    assign tag_in   = addr_i[31 -: TAG_BITS];
    assign word_off = addr_i[2 +: WORD_BITS];
    assign hit      = valid_q[index] && (tag_q[index] == tag_in);

    assign ready_o = valid_i && hit;
    assign instr_o = hit ? line_q[index][word_off*32 +: 32] : '0;

    logic                  pending_q;    // line request outstanding
    logic [INDEX_BITS-1:0] miss_idx_q;
    logic [TAG_BITS-1:0]   miss_tag_q;
    logic                  miss_start;

    assign miss_start = valid_i && !hit && !pending_q;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pending_q <= 1'b0;
            for (int i = 0; i < NUM_LINES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else begin
            if (miss_start) begin
                pending_q <= 1'b1;
            end else if (mem.rsp_valid) begin
                pending_q           <= 1'b0;
                valid_q[miss_idx_q] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (miss_start) begin
            miss_idx_q <= index;
            miss_tag_q <= tag_in;
        end
        if (mem.rsp_valid) begin
            tag_q[miss_idx_q]  <= miss_tag_q;
            line_q[miss_idx_q] <= mem.rdata;
        end
    end

    assign mem.req_valid = pending_q;
    assign mem.we        = 1'b0;    // read only
    assign mem.addr      = {miss_tag_q, miss_idx_q, {OFFSET_BITS{1'b0}}};
    assign mem.wdata     = '0;

    // a fetch still held hits in the cycle after its line arrives
    a_fill_hit: assert property (@(posedge clk_i) disable iff (!rstn_i)
        mem.rsp_valid |=> (ready_o || !valid_i));

endmodule

//--- main_memory.sv
`timescale 1ns/10ps
`include "tartaruga_consts.svh"

module main_memory (
    input  logic      clk_i,
    input  logic      rstn_i,
    mem_bus_if.memory bus
);

    import riscv_pkg::*;
    import tartaruga_pkg::*;

    localparam int WADDR_BITS = $clog2(`MEM_WORDS);
    localparam int CNT_BITS   = $clog2(`MEM_LATENCY + 1);

    bus32_t                words_q [`MEM_WORDS];
    line_t                 rdata_q;
    logic                  busy_q;
    logic [CNT_BITS-1:0]   cnt_q;
    logic                  accept;
    logic [WADDR_BITS-1:0] base;    // word index of the line, wraps

    assign base          = bus.addr[2 +: WADDR_BITS];
    assign accept        = bus.req_valid && bus.req_ready;
    assign bus.req_ready = !busy_q;
    assign bus.rsp_valid = busy_q && (cnt_q == '0);
    assign bus.rdata     = rdata_q;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
            for (int i = 0; i < `MEM_WORDS; i++) begin
                words_q[i] <= bus32_t'(i) ^ `MEM_INIT_PATTERN;
            end
        end else begin
            if (accept) begin
                busy_q <= 1'b1;
                cnt_q  <= CNT_BITS'(`MEM_LATENCY - 1);
                if (bus.we) begin
                    for (int k = 0; k < `WORDS_PER_LINE; k++) begin
                        words_q[base + WADDR_BITS'(k)] <= bus.wdata[k*32 +: 32];
                    end
                end
            end else if (busy_q) begin
                if (cnt_q == '0) begin
                    busy_q <= 1'b0;
                end else begin
                    cnt_q <= cnt_q - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            for (int k = 0; k < `WORDS_PER_LINE; k++) begin
                rdata_q[k*32 +: 32] <= words_q[base + WADDR_BITS'(k)];
            end
        end
    end

    // one transaction at a time, each response pairs with its acceptance
    a_fixed_latency: assert property (@(posedge clk_i) disable iff (!rstn_i)
        bus.rsp_valid |-> $past(accept, `MEM_LATENCY));

endmodule

//--- mem_arbiter.sv
`timescale 1ns/10ps

module mem_arbiter (
    input  logic         clk_i,
    input  logic         rstn_i,
    mem_bus_if.memory    ic,
    mem_bus_if.memory    dc,
    mem_bus_if.requester mem
);

    logic busy_q;        // a transaction is in flight
    logic owner_dc_q;    // owner of the transaction in flight
    logic sel_dc;
    logic accept;

    // dcache wins when both ask in the same idle cycle
    assign sel_dc = busy_q ? owner_dc_q : dc.req_valid;
    assign accept = mem.req_valid && mem.req_ready;

    assign mem.req_valid = sel_dc ? dc.req_valid : ic.req_valid;
    assign mem.we        = sel_dc ? dc.we : ic.we;
    assign mem.addr      = sel_dc ? dc.addr : ic.addr;
    assign mem.wdata     = sel_dc ? dc.wdata : ic.wdata;

    assign dc.req_ready = sel_dc && mem.req_ready;
    assign ic.req_ready = !sel_dc && mem.req_ready;

    assign dc.rsp_valid = busy_q && owner_dc_q && mem.rsp_valid;
    assign ic.rsp_valid = busy_q && !owner_dc_q && mem.rsp_valid;

    assign dc.rdata = mem.rdata;
    assign ic.rdata = mem.rdata;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            busy_q     <= 1'b0;
            owner_dc_q <= 1'b0;
        end else begin
            if (accept) begin
                busy_q     <= 1'b1;
                owner_dc_q <= sel_dc;
            end else if (mem.rsp_valid) begin
                busy_q <= 1'b0;
            end
        end
    end

    a_one_rsp: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(ic.rsp_valid && dc.rsp_valid));

    // the response goes to a cache that is still waiting for it
    a_rsp_to_waiter: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (dc.rsp_valid |-> dc.req_valid) and (ic.rsp_valid |-> ic.req_valid));

endmodule

//--- mem_bus_if.sv
`timescale 1ns/10ps

interface mem_bus_if;

    import riscv_pkg::*;
    import tartaruga_pkg::*;

    logic   req_valid;    // held until rsp_valid
    logic   we;
    bus32_t addr;         // line aligned
    line_t  wdata;
    logic   req_ready;
    line_t  rdata;
    logic   rsp_valid;    // one-cycle pulse

    modport requester (
        output req_valid,
        output we,
        output addr,
        output wdata,
        input  req_ready,
        input  rdata,
        input  rsp_valid
    );

    modport memory (
        input  req_valid,
        input  we,
        input  addr,
        input  wdata,
        output req_ready,
        output rdata,
        output rsp_valid
    );

endinterface

//--- riscv_pkg.sv
package riscv_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] bus32_t;    // address or data word
    typedef logic [XLEN-1:0] instr_t;    // fetched instruction

endpackage

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tartaruga_mem.f \
    --top-module tb_tartaruga_mem -o tb_tartaruga_mem

./obj_dir/tb_tartaruga_mem

//--- tartaruga_consts.svh
`ifndef TARTARUGA_CONSTS_SVH
`define TARTARUGA_CONSTS_SVH

// data cache geometry
`define DC_NUM_SETS      16
`define DC_WAYS          2

// instruction cache size in lines
`define IC_NUM_LINES     16

`define WORDS_PER_LINE   4

// cycles from an accepted request to the response pulse
`define MEM_LATENCY      3

`define MEM_WORDS        1024            // addresses wrap modulo this size

// at reset word i of main memory holds i ^ MEM_INIT_PATTERN
`define MEM_INIT_PATTERN 32'h5A3C_96E1

`endif

//--- tartaruga_mem.f
+incdir+.
riscv_pkg.sv
tartaruga_pkg.sv
mem_bus_if.sv
dcache.sv
icache.sv
mem_arbiter.sv
main_memory.sv
tartaruga_mem_top.sv
tb_tartaruga_mem.sv

//--- tartaruga_mem_cases.txt
# port op address data ; d w = data write, d r = data read, i r = fetch, i s = fetch of old word
# b r = data read at address with a fetch at data in one cycle ; rnd mix = random run, data = count
d r 00000100 00000000
d r 00000100 00000000
d w 00000208 cafe0001
d r 00000208 00000000
d r 00000200 00000000
d r 00000204 00000000
d r 0000020c 00000000
# three lines in set 3, the dirty one gets evicted
d w 00000030 11110030
d w 0000003c 1111003c
d r 00000130 00000000
d r 00000230 00000000
d r 00000030 00000000
d r 00000034 00000000
d r 0000003c 00000000
# fetch miss then hits in the same line
i r 00000800 00000000
i r 00000804 00000000
i r 00000800 00000000
d w 00000850 0badf00d
i s 00000850 00000000
d r 00000850 00000000
b r 000006a0 000007c4
rnd mix 00000400 00000028

//--- tartaruga_mem_top.sv
`timescale 1ns/10ps

module tartaruga_mem_top (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  riscv_pkg::bus32_t if_addr_i,
    input  logic              if_valid_i,
    output riscv_pkg::instr_t if_instr_o,
    output logic              if_ready_o,
    input  riscv_pkg::bus32_t dc_addr_i,
    input  riscv_pkg::bus32_t dc_wdata_i,
    input  logic              dc_we_i,
    input  logic              dc_valid_i,
    output riscv_pkg::bus32_t dc_rdata_o,
    output logic              dc_ready_o
);

    mem_bus_if ic_bus ();
    mem_bus_if dc_bus ();
    mem_bus_if mem_bus ();

    icache u_icache (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .addr_i  (if_addr_i),
        .valid_i (if_valid_i),
        .instr_o (if_instr_o),
        .ready_o (if_ready_o),
        .mem     (ic_bus)
    );

    dcache u_dcache (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .addr_i    (dc_addr_i),
        .data_wr_i (dc_wdata_i),
        .we_i      (dc_we_i),
        .valid_i   (dc_valid_i),
        .data_rd_o (dc_rdata_o),
        .ready_o   (dc_ready_o),
        .mem       (dc_bus)
    );

    mem_arbiter u_mem_arbiter (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .ic     (ic_bus),
        .dc     (dc_bus),
        .mem    (mem_bus)
    );

    main_memory u_main_memory (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .bus    (mem_bus)
    );

endmodule

//--- tartaruga_pkg.sv
`include "tartaruga_consts.svh"

package tartaruga_pkg;

    typedef logic [`WORDS_PER_LINE*32-1:0] line_t;    // word 0 in the low bits

    typedef logic way_t;

    typedef logic age_t;    // 1 marks the older way of a set

    typedef enum logic [1:0] {
        IDLE,
        WRITE_BACK,
        READ_MISS,
        WRITE_MISS
    } dc_state_t;

endpackage

//--- tb_tartaruga_mem.sv
`timescale 1ns/10ps
`include "tartaruga_consts.svh"

module tb_tartaruga_mem;

    import riscv_pkg::*;

    localparam int TIMEOUT_CYCLES = 200;

    logic   clk;
    logic   rstn;
    bus32_t if_addr;
    logic   if_valid;
    instr_t if_instr;
    logic   if_ready;
    bus32_t dc_addr;
    bus32_t dc_wdata;
    logic   dc_we;
    logic   dc_valid;
    bus32_t dc_rdata;
    logic   dc_ready;

    bus32_t      ref_mem [`MEM_WORDS];    // what the data port must see
    logic [15:0] lfsr_q;

    tartaruga_mem_top u_tartaruga_mem_top (
        .clk_i      (clk),
        .rstn_i     (rstn),
        .if_addr_i  (if_addr),
        .if_valid_i (if_valid),
        .if_instr_o (if_instr),
        .if_ready_o (if_ready),
        .dc_addr_i  (dc_addr),
        .dc_wdata_i (dc_wdata),
        .dc_we_i    (dc_we),
        .dc_valid_i (dc_valid),
        .dc_rdata_o (dc_rdata),
        .dc_ready_o (dc_ready)
    );

    always #10 clk = ~clk;

    function automatic bus32_t init_word(input int idx);
        return 32'(idx) ^ `MEM_INIT_PATTERN;
    endfunction

    function automatic int word_index(input bus32_t addr);
        return int'((addr >> 2) % `MEM_WORDS);    // memory wraps
    endfunction

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};    // x^16+x^14+x^13+x^11+1
    endfunction

    task automatic random_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v      = {v[30:0], lfsr_q[0]};
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input bus32_t got, input bus32_t exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            abort_run("value check failed");
        end
    endtask

    task automatic data_access(input logic we, input bus32_t addr, input bus32_t wdata,
                               output bus32_t rdata);
        int cycles;
        logic done;
        cycles = 0;
        done   = 1'b0;
        rdata  = '0;
        @(posedge clk);
        dc_valid <= 1'b1;
        dc_we    <= we;
        dc_addr  <= addr;
        dc_wdata <= wdata;
        while (!done) begin
            @(negedge clk);
            if (dc_ready) begin
                done  = 1'b1;
                rdata = dc_rdata;
            end else begin
                cycles++;
                if (cycles >= TIMEOUT_CYCLES) begin
                    abort_run($sformatf("data port ready never came for address %h", addr));
                end
            end
        end
        @(posedge clk);    // a hit write commits at this edge
        dc_valid <= 1'b0;
        dc_we    <= 1'b0;
    endtask

    task automatic fetch(input bus32_t addr, output bus32_t instr);
        int cycles;
        logic done;
        cycles = 0;
        done   = 1'b0;
        instr  = '0;
        @(posedge clk);
        if_valid <= 1'b1;
        if_addr  <= addr;
        while (!done) begin
            @(negedge clk);
            if (if_ready) begin
                done  = 1'b1;
                instr = if_instr;
            end else begin
                cycles++;
                if (cycles >= TIMEOUT_CYCLES) begin
                    abort_run($sformatf("fetch port ready never came for address %h", addr));
                end
            end
        end
        @(posedge clk);
        if_valid <= 1'b0;
    endtask

    // data read and fetch raised in the same cycle
    task automatic both_access(input bus32_t d_addr, input bus32_t i_addr,
                               output bus32_t d_data, output bus32_t i_data);
        int cycles;
        logic d_done;
        logic i_done;
        cycles = 0;
        d_done = 1'b0;
        i_done = 1'b0;
        d_data = '0;
        i_data = '0;
        @(posedge clk);
        dc_valid <= 1'b1;
        dc_we    <= 1'b0;
        dc_addr  <= d_addr;
        if_valid <= 1'b1;
        if_addr  <= i_addr;
        while (!(d_done && i_done)) begin
            @(negedge clk);
            if (!d_done && dc_ready) begin
                d_done = 1'b1;
                d_data = dc_rdata;
            end
            if (!i_done && if_ready) begin
                i_done = 1'b1;
                i_data = if_instr;
            end
            if (!(d_done && i_done)) begin
                cycles++;
                if (cycles >= TIMEOUT_CYCLES) begin
                    abort_run("ready never came on the data or the fetch port");
                end
            end
        end
        @(posedge clk);
        dc_valid <= 1'b0;
        if_valid <= 1'b0;
    endtask

    task automatic random_run(input bus32_t base, input int count);
        logic [31:0] we_bit;
        logic [31:0] word;
        logic [31:0] data;
        bus32_t      addr;
        bus32_t      got;
        for (int n = 0; n < count; n++) begin
            random_bits(1, we_bit);
            random_bits(6, word);    // 64-word window
            addr = base + (word << 2);
            if (we_bit[0]) begin
                random_bits(32, data);
                data_access(1'b1, addr, data, got);
                ref_mem[word_index(addr)] = data;
            end else begin
                data_access(1'b0, addr, '0, got);
                check_value(got, ref_mem[word_index(addr)],
                            $sformatf("random read %0d at %h", n, addr));
            end
        end
    endtask

    task automatic run_case(input string port, input string op, input bus32_t addr,
                            input bus32_t arg);
        bus32_t got;
        bus32_t got_i;
        if (port == "d" && op == "w") begin
            data_access(1'b1, addr, arg, got);
            ref_mem[word_index(addr)] = arg;
        end else if (port == "d" && op == "r") begin
            data_access(1'b0, addr, '0, got);
            check_value(got, ref_mem[word_index(addr)], $sformatf("data read at %h", addr));
        end else if (port == "i" && op == "r") begin
            fetch(addr, got);
            check_value(got, ref_mem[word_index(addr)], $sformatf("fetch at %h", addr));
        end else if (port == "i" && op == "s") begin
            fetch(addr, got);    // without coherence the memory still holds the old word
            check_value(got, init_word(word_index(addr)), $sformatf("stale fetch at %h", addr));
        end else if (port == "b" && op == "r") begin
            both_access(addr, arg, got, got_i);
            check_value(got, ref_mem[word_index(addr)], $sformatf("data read at %h", addr));
            check_value(got_i, ref_mem[word_index(arg)], $sformatf("fetch at %h", arg));
        end else if (port == "rnd" && op == "mix") begin
            random_run(addr, int'(arg));
        end else begin
            abort_run($sformatf("unknown case %s %s in the cases file", port, op));
        end
    endtask

    initial begin
        int    fd;
        string port;
        string op;
        string rest;
        bus32_t addr;
        bus32_t arg;
        clk      = 1'b0;
        rstn     = 1'b0;
        if_addr  = '0;
        if_valid = 1'b0;
        dc_addr  = '0;
        dc_wdata = '0;
        dc_we    = 1'b0;
        dc_valid = 1'b0;
        lfsr_q   = 16'd64179;
        for (int i = 0; i < `MEM_WORDS; i++) begin
            ref_mem[i] = init_word(i);
        end
        fd = $fopen("tartaruga_mem_cases.txt", "r");
        if (fd == 0) begin
            abort_run("could not open tartaruga_mem_cases.txt");
        end
        repeat (4) @(posedge clk);
        rstn <= 1'b1;
        while ($fscanf(fd, "%s", port) == 1) begin
            if (port.substr(0, 0) == "#") begin
                void'($fgets(rest, fd));    // skip the rest of a comment line
            end else begin
                if ($fscanf(fd, "%s %h %h", op, addr, arg) != 3) begin
                    abort_run("malformed line in the cases file");
                end
                run_case(port, op, addr, arg);
            end
        end
        $fclose(fd);
        $display("Test passed");
        $finish;
    end

endmodule
